// ==== compile.f ====
logic/fir_pkg.sv
logic/fir_coef_store.sv
logic/fir_sample_buffer.sv
logic/fir_mac.sv
logic/fir_cfg_bus.sv
logic/fir_ctrl.sv
logic/fir_top.sv
tb/fir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module fir_tb -o fir_sim \
    && ./obj_dir/fir_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
grep -q "Testbench passed" sim.log || exit 1
exit 0

// ==== tb/fir_tb.sv ====
`timescale 1ns/1ns
module fir_tb;
    import fir_pkg::*;

    localparam int NUM_TAPS  = 11;
    localparam int NUM_TESTS = 3;
    localparam int MAX_LEN   = 16;
    localparam longint WATCHDOG_NS =
        (NUM_TESTS + 1) * (MAX_LEN + NUM_TAPS + 4) * (NUM_TAPS + 20) * 20;

    typedef struct packed {
        logic [1:0] mode;     // 0 small values, 1 large magnitudes, 2 full range.
        logic [7:0] len;
        logic [7:0] bp;       // sm_tready pattern, one bit per cycle.
        ap_status_t exp_end;  // Status expected right after the last output.
    } test_t;

    localparam test_t TESTS [NUM_TESTS] = '{
        '{mode: 2'd0, len: 8'd16, bp: 8'hFF, exp_end: 3'b110},
        '{mode: 2'd1, len: 8'd10, bp: 8'h6B, exp_end: 3'b110},
        '{mode: 2'd2, len: 8'd12, bp: 8'h01, exp_end: 3'b110}
    };

    logic    axis_clk = 1'b0;
    logic    axis_rst_n;
    logic    awvalid, wvalid, arvalid, rready;
    addr_t   awaddr, araddr;
    sample_t wdata, rdata;
    logic    awready, wready, arready, rvalid;
    logic    ss_tvalid, ss_tlast, ss_tready;
    sample_t ss_tdata, sm_tdata;
    logic    sm_tvalid, sm_tlast, sm_tready;

    int      seed = 11205;
    int      errors = 0;
    int      checks = 0;
    int      failed_tests = 0;
    int      err_before;
    int      sat_count;
    sample_t rd;
    test_t   cfg;
    sample_t h [NUM_TAPS];
    sample_t x [MAX_LEN];
    sample_t y_exp [MAX_LEN];

    fir_top #(.NUM_TAPS(NUM_TAPS)) fir_top_inst (.*);

    always #10 axis_clk = ~axis_clk;

    task automatic check_sample(input string what, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s gave %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input string what, input ap_status_t got, input ap_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s gave start=%0b done=%0b idle=%0b, expected %0b %0b %0b",
                     $time, what, got.start, got.done, got.idle, exp.start, exp.done, exp.idle);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s was %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    function automatic sample_t sat_mul(input sample_t a, input sample_t b);
        longint p;
        p = longint'(a) * longint'(b);
        if (p > longint'(SAT_MAX)) return SAT_MAX;
        if (p < longint'(SAT_MIN)) return SAT_MIN;
        return sample_t'(p);
    endfunction

    function automatic sample_t sat_add(input sample_t a, input sample_t b);
        longint s;
        s = longint'(a) + longint'(b);
        if (s > longint'(SAT_MAX)) return SAT_MAX;
        if (s < longint'(SAT_MIN)) return SAT_MIN;
        return sample_t'(s);
    endfunction

    function automatic sample_t pick_value(input logic [1:0] mode, input int range);
        sample_t r;
        sample_t mag;
        r = $random(seed);
        mag = (r & 32'h3FFF_FFFF) | 32'h4000_0000;  // At least 2^30, so products overflow.
        case (mode)
            2'd0: return r % range;
            2'd1: return r[31] ? -mag : mag;
            default: return r;
        endcase
    endfunction

    // Direct form sum, saturating each product and each partial sum in tap order.
    task automatic build_expected(input int len);
        sample_t acc;
        for (int n = 0; n < len; n++) begin
            acc = '0;
            for (int k = 0; k < NUM_TAPS; k++) begin
                if (n - k >= 0) acc = sat_add(acc, sat_mul(h[k], x[n - k]));
            end
            y_exp[n] = acc;
        end
    endtask

    // Callers are on a falling edge, and every bus task returns on one.
    task automatic axil_write(input addr_t addr, input sample_t data);
        bit aw_done;
        bit w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (!(aw_done && w_done)) begin
            @(negedge axis_clk);
            if (awready) begin
                aw_done = 1'b1;
                awvalid = 1'b0;
            end
            if (wready) begin
                w_done = 1'b1;
                wvalid = 1'b0;
            end
        end
        @(negedge axis_clk);
    endtask

    task automatic axil_read(input addr_t addr, output sample_t data);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge axis_clk);
        data = rdata;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic send_samples(input int len);
        for (int n = 0; n < len; n++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = x[n];
            ss_tlast  = (n == len - 1);
            while (!ss_tready) @(negedge axis_clk);
            @(negedge axis_clk);  // The transfer happened on the edge just passed.
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_outputs(input int len, input logic [7:0] bp);
        int      got;
        int      cyc;
        logic    held;
        sample_t held_data;
        got = 0;
        cyc = 0;
        held = 1'b0;
        held_data = '0;
        while (got < len) begin
            @(negedge axis_clk);
            sm_tready = bp[cyc % 8];
            cyc++;
            if (held) begin
                check_flag("valid held under back-pressure", sm_tvalid, 1'b1);
                check_sample("data held under back-pressure", sm_tdata, held_data);
            end
            held = 1'b0;
            if (sm_tvalid) begin
                check_flag("input ready while output waits", ss_tready, 1'b0);
                if (sm_tready) begin
                    check_sample("filter output", sm_tdata, y_exp[got]);
                    check_flag("last flag", sm_tlast, got == len - 1);
                    got++;
                end else begin
                    held = 1'b1;
                    held_data = sm_tdata;
                end
            end
        end
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        axis_rst_n = 1'b0;
        {awvalid, wvalid, arvalid, rready, ss_tvalid, ss_tlast, sm_tready} = '0;
        {awaddr, araddr} = '0;
        {wdata, ss_tdata} = '0;
        repeat (4) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;

        err_before = errors;
        // Every handshake output comes out of reset inactive.
        check_flag("awready after reset", awready, 1'b0);
        check_flag("wready after reset", wready, 1'b0);
        check_flag("arready after reset", arready, 1'b0);
        check_flag("rvalid after reset", rvalid, 1'b0);
        check_flag("ss_tready after reset", ss_tready, 1'b0);
        check_flag("sm_tvalid after reset", sm_tvalid, 1'b0);
        check_flag("sm_tlast after reset", sm_tlast, 1'b0);

        // A start with only part of the configuration written must not leave idle.
        axil_read(ADDR_AP_CTRL, rd);
        check_status("status after reset", ap_status_t'(rd[2:0]), 3'b100);
        axil_write(ADDR_DATA_LEN, 32'd5);
        axil_write(ADDR_TAP_BASE, 32'd7);
        axil_write(ADDR_AP_CTRL, 32'd1);
        axil_read(ADDR_AP_CTRL, rd);
        check_status("status after early start", ap_status_t'(rd[2:0]), 3'b100);
        if (errors > err_before) failed_tests++;
        $display("Test reset: %0d errors", errors - err_before);

        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before = errors;
            cfg = TESTS[t];
            for (int k = 0; k < NUM_TAPS; k++) begin
                h[k] = pick_value(cfg.mode, 256);
                axil_write(addr_t'(ADDR_TAP_BASE + 4 * k), h[k]);
            end
            for (int n = 0; n < cfg.len; n++) begin
                x[n] = pick_value(cfg.mode, 4096);
            end
            build_expected(cfg.len);
            sat_count = 0;
            for (int n = 0; n < cfg.len; n++) begin
                if (y_exp[n] == SAT_MAX || y_exp[n] == SAT_MIN) sat_count++;
            end
            axil_write(ADDR_DATA_LEN, sample_t'(cfg.len));
            for (int k = 0; k < NUM_TAPS; k++) begin
                axil_read(addr_t'(ADDR_TAP_BASE + 4 * k), rd);
                check_sample("tap read-back", rd, h[k]);
            end
            axil_read(ADDR_DATA_LEN, rd);
            check_sample("count read-back", rd, sample_t'(cfg.len));
            axil_read(12'h008, rd);
            check_sample("unmapped read", rd, '1);

            axil_write(ADDR_AP_CTRL, 32'd1);
            fork
                send_samples(cfg.len);
                collect_outputs(cfg.len, cfg.bp);
            join
            repeat (3) @(negedge axis_clk);
            check_flag("extra output valid", sm_tvalid, 1'b0);

            axil_read(ADDR_AP_CTRL, rd);
            check_status("status after run", ap_status_t'(rd[2:0]), cfg.exp_end);
            axil_read(ADDR_AP_CTRL, rd);
            check_status("status after done read", ap_status_t'(rd[2:0]), 3'b100);
            axil_write(ADDR_AP_CTRL, 32'd1);  // Flags were cleared at finish.
            axil_read(ADDR_AP_CTRL, rd);
            check_status("status after restart", ap_status_t'(rd[2:0]), 3'b100);

            if (errors > err_before) failed_tests++;
            $display("Test %0d: mode %0d, %0d samples, ready pattern %h, %0d saturated, %0d errors",
                     t, cfg.mode, cfg.len, cfg.bp, sat_count, errors - err_before);
        end

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS + 1, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== logic/fir_top.sv ====
`timescale 1ns/1ns
module fir_top #(
    parameter int NUM_TAPS = 11
) (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              awvalid,
    input  fir_pkg::addr_t    awaddr,
    output logic              awready,
    input  logic              wvalid,
    input  fir_pkg::sample_t  wdata,
    output logic              wready,
    input  logic              arvalid,
    input  fir_pkg::addr_t    araddr,
    output logic              arready,
    output logic              rvalid,
    output fir_pkg::sample_t  rdata,
    input  logic              rready,
    input  logic              ss_tvalid,
    input  fir_pkg::sample_t  ss_tdata,
    input  logic              ss_tlast,
    output logic              ss_tready,
    output logic              sm_tvalid,
    output fir_pkg::sample_t  sm_tdata,
    output logic              sm_tlast,
    input  logic              sm_tready
);
    import fir_pkg::*;

    localparam int IDX_W = $clog2(NUM_TAPS);

    cfg_wr_t           cfg_wr;
    ap_status_t        ap_status;
    sample_t           data_len;
    logic [ADDR_W-3:0] coef_rd_idx;
    sample_t           coef_rd_data;
    logic              ctrl_read;
    logic              tap_we;
    logic              buf_clear;
    logic              buf_push;
    logic [IDX_W-1:0]  tap_idx;
    logic              mac_clear;
    logic              mac_capture;
    sample_t           mac_coef;
    sample_t           buf_sample;
    mac_op_t           mac_op;

    // Tap k is paired with the sample k steps older than the newest.
    assign mac_op = '{clear: mac_clear, coef: mac_coef, sample: buf_sample};

    fir_cfg_bus fir_cfg_bus_inst (
        .axis_clk, .axis_rst_n,
        .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
        .arvalid, .araddr, .arready, .rvalid, .rdata, .rready,
        .cfg_wr, .ap_status, .data_len, .coef_rd_idx, .coef_rd_data, .ctrl_read
    );

    fir_ctrl #(.NUM_TAPS(NUM_TAPS)) fir_ctrl_inst (
        .axis_clk, .axis_rst_n, .cfg_wr, .ctrl_read, .ap_status, .data_len, .tap_we,
        .ss_tvalid, .ss_tlast, .ss_tready, .sm_tready, .sm_tvalid, .sm_tlast,
        .buf_clear, .buf_push, .tap_idx, .mac_clear, .mac_capture
    );

    fir_coef_store #(.NUM_TAPS(NUM_TAPS)) fir_coef_store_inst (
        .axis_clk,
        .cfg_wr,
        .tap_we,
        .mac_idx  (tap_idx),
        .mac_coef (mac_coef),
        .cfg_idx  (coef_rd_idx),
        .cfg_coef (coef_rd_data)
    );

    fir_sample_buffer #(.NUM_TAPS(NUM_TAPS)) fir_sample_buffer_inst (
        .axis_clk,
        .axis_rst_n,
        .clear     (buf_clear),
        .push      (buf_push),
        .push_data (ss_tdata),
        .age       (tap_idx),
        .sample    (buf_sample)
    );

    fir_mac fir_mac_inst (
        .axis_clk,
        .axis_rst_n,
        .op       (mac_op),
        .capture  (mac_capture),
        .sm_tdata (sm_tdata)
    );

endmodule

// ==== logic/fir_ctrl.sv ====
`timescale 1ns/1ns
module fir_ctrl #(
    parameter int NUM_TAPS = 11
) (
    input  logic                         axis_clk,
    input  logic                         axis_rst_n,
    input  fir_pkg::cfg_wr_t             cfg_wr,
    input  logic                         ctrl_read,
    output fir_pkg::ap_status_t          ap_status,
    output fir_pkg::sample_t             data_len,
    output logic                         tap_we,
    input  logic                         ss_tvalid,
    input  logic                         ss_tlast,
    output logic                         ss_tready,
    input  logic                         sm_tready,
    output logic                         sm_tvalid,
    output logic                         sm_tlast,
    output logic                         buf_clear,
    output logic                         buf_push,
    output logic [$clog2(NUM_TAPS)-1:0]  tap_idx,
    output logic                         mac_clear,
    output logic                         mac_capture
);
    import fir_pkg::*;

    localparam int IDX_W = $clog2(NUM_TAPS);
    localparam logic [IDX_W-1:0] LAST_TAP = IDX_W'(NUM_TAPS - 1);

    fir_state_e          state;
    fir_state_e          next_state;
    logic [NUM_TAPS-1:0] tap_set;
    logic                len_set;
    logic [ADDR_W-3:0]   wr_idx;
    logic                wr_ctrl;
    logic                wr_len;
    logic                start_ok;
    logic                x_last;
    logic                out_done;

    assign wr_idx  = cfg_wr.addr[ADDR_W-1:2] - ADDR_TAP_BASE[ADDR_W-1:2];
    assign wr_ctrl = cfg_wr.valid && (state == IDLE) && (cfg_wr.addr == ADDR_AP_CTRL);
    assign wr_len  = cfg_wr.valid && (state == IDLE) && (cfg_wr.addr == ADDR_DATA_LEN);
    assign tap_we  = cfg_wr.valid && (state == IDLE) && (cfg_wr.addr >= ADDR_TAP_BASE)
                     && (cfg_wr.addr[1:0] == 2'b00) && (wr_idx < NUM_TAPS);

    // Start only counts once the length and every tap have been written.
    assign start_ok = wr_ctrl && cfg_wr.data[0] && ap_status.idle && len_set && (&tap_set);

    assign ss_tready   = (state == WAIT_IN);
    assign buf_push    = ss_tvalid && ss_tready;
    assign buf_clear   = (state == IDLE) && ap_status.start;
    assign mac_clear   = (state == CALC) && (tap_idx == '0);
    assign out_done    = sm_tvalid && sm_tready;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (ap_status.start) next_state = WAIT_IN;
            WAIT_IN: if (buf_push) next_state = CALC;
            CALC:    if (tap_idx == LAST_TAP) next_state = OUT;
            OUT:     if (out_done) next_state = x_last ? FINISH : WAIT_IN;
            FINISH:  next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state       <= IDLE;
            ap_status   <= '{idle: 1'b1, done: 1'b0, start: 1'b0};
            data_len    <= '0;
            len_set     <= 1'b0;
            tap_set     <= '0;
            tap_idx     <= '0;
            mac_capture <= 1'b0;
            sm_tvalid   <= 1'b0;
            sm_tlast    <= 1'b0;
        end else begin
            state <= next_state;
            if (start_ok) begin
                ap_status.start <= 1'b1;
                ap_status.idle  <= 1'b0;
            end else if (buf_clear) begin
                ap_status.start <= 1'b0;
            end
            if (state == FINISH) begin
                ap_status.done <= 1'b1;
                ap_status.idle <= 1'b1;
                len_set        <= 1'b0;
                tap_set        <= '0;
            end else begin
                if (ctrl_read) ap_status.done <= 1'b0;
                if (wr_len) begin
                    data_len <= cfg_wr.data;  // Stored for read-back only.
                    len_set  <= 1'b1;
                end
                for (int k = 0; k < NUM_TAPS; k++) begin
                    if (tap_we && wr_idx == k) tap_set[k] <= 1'b1;
                end
            end
            if (state == CALC && tap_idx != LAST_TAP) begin
                tap_idx <= tap_idx + 1'b1;
            end else begin
                tap_idx <= '0;
            end
            // The accumulator holds the full sum one cycle after the last step.
            mac_capture <= (state == CALC) && (tap_idx == LAST_TAP);
            if (mac_capture) begin
                sm_tvalid <= 1'b1;
                sm_tlast  <= x_last;
            end else if (out_done) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (buf_push) begin
            x_last <= ss_tlast;
        end
    end

endmodule

// ==== logic/fir_cfg_bus.sv ====
`timescale 1ns/1ns
module fir_cfg_bus (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        awvalid,
    input  fir_pkg::addr_t              awaddr,
    output logic                        awready,
    input  logic                        wvalid,
    input  fir_pkg::sample_t            wdata,
    output logic                        wready,
    input  logic                        arvalid,
    input  fir_pkg::addr_t              araddr,
    output logic                        arready,
    output logic                        rvalid,
    output fir_pkg::sample_t            rdata,
    input  logic                        rready,
    output fir_pkg::cfg_wr_t            cfg_wr,
    input  fir_pkg::ap_status_t         ap_status,
    input  fir_pkg::sample_t            data_len,
    output logic [fir_pkg::ADDR_W-3:0]  coef_rd_idx,
    input  fir_pkg::sample_t            coef_rd_data,
    output logic                        ctrl_read
);
    import fir_pkg::*;

    addr_t     awaddr_q;
    sample_t   wdata_q;
    logic      aw_held;
    logic      w_held;
    logic      aw_take;
    logic      w_take;
    rd_state_e rd_state;
    addr_t     araddr_q;
    logic      rd_is_tap;
    sample_t   rd_value;

    assign aw_take = awvalid && !aw_held && !awready;
    assign w_take  = wvalid && !w_held && !wready;

    // Address and data may arrive in either order; the strobe fires once both are held.
    assign cfg_wr.valid = aw_held && w_held;
    assign cfg_wr.addr  = awaddr_q;
    assign cfg_wr.data  = wdata_q;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            awready <= aw_take;
            wready  <= w_take;
            if (cfg_wr.valid) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end else begin
                if (aw_take) begin
                    aw_held <= 1'b1;
                end
                if (w_take) begin
                    w_held <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (aw_take) begin
            awaddr_q <= awaddr;
        end
        if (w_take) begin
            wdata_q <= wdata;
        end
    end

    assign arready   = (rd_state == RD_ADDR);
    assign rvalid    = (rd_state == RD_DATA);
    assign ctrl_read = rvalid && rready && (araddr_q == ADDR_AP_CTRL);

    // Any aligned address from the tap base up is a tap; the store answers for missing taps.
    assign rd_is_tap   = (araddr_q >= ADDR_TAP_BASE) && (araddr_q[1:0] == 2'b00);
    assign coef_rd_idx = araddr_q[ADDR_W-1:2] - ADDR_TAP_BASE[ADDR_W-1:2];

    always_comb begin
        if (araddr_q == ADDR_AP_CTRL) begin
            rd_value = {{(DATA_W-3){1'b0}}, ap_status};
        end else if (araddr_q == ADDR_DATA_LEN) begin
            rd_value = data_len;
        end else if (rd_is_tap) begin
            rd_value = coef_rd_data;
        end else begin
            rd_value = '1;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (arvalid) rd_state <= RD_ADDR;
                RD_ADDR: rd_state <= RD_DATA;
                RD_DATA: if (rready) rd_state <= RD_IDLE;  // rvalid holds until taken.
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_state == RD_IDLE && arvalid) begin
            araddr_q <= araddr;
        end
        if (rd_state == RD_ADDR) begin
            rdata <= rd_value;
        end
    end

endmodule

// ==== logic/fir_mac.sv ====
`timescale 1ns/1ns
module fir_mac (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  fir_pkg::mac_op_t  op,
    input  logic              capture,
    output fir_pkg::sample_t  sm_tdata
);
    import fir_pkg::*;

    logic signed [2*DATA_W-1:0] prod_full;
    logic                       prod_ovf;
    sample_t                    prod;
    sample_t                    addend;
    logic signed [DATA_W:0]     sum_full;
    logic                       sum_ovf;
    sample_t                    sum;
    sample_t                    acc;

    assign prod_full = $signed(op.coef) * $signed(op.sample);

    // The product fits only if the top DATA_W+1 bits are pure sign.
    assign prod_ovf = prod_full[2*DATA_W-1:DATA_W-1] != {(DATA_W+1){prod_full[2*DATA_W-1]}};

    always_comb begin
        if (prod_ovf) begin
            prod = prod_full[2*DATA_W-1] ? SAT_MIN : SAT_MAX;
        end else begin
            prod = prod_full[DATA_W-1:0];
        end
    end

    assign addend   = op.clear ? '0 : acc;  // Step 0 starts a fresh sum.
    assign sum_full = {addend[DATA_W-1], addend} + {prod[DATA_W-1], prod};
    assign sum_ovf  = sum_full[DATA_W] ^ sum_full[DATA_W-1];

    always_comb begin
        if (sum_ovf) begin
            sum = sum_full[DATA_W] ? SAT_MIN : SAT_MAX;
        end else begin
            sum = sum_full[DATA_W-1:0];
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            acc      <= '0;
            sm_tdata <= '0;
        end else begin
            acc <= sum;
            if (capture) begin
                sm_tdata <= acc;  // Holds through back-pressure.
            end
        end
    end

endmodule

// ==== logic/fir_sample_buffer.sv ====
`timescale 1ns/1ns
module fir_sample_buffer #(
    parameter int NUM_TAPS = 11
) (
    input  logic                         axis_clk,
    input  logic                         axis_rst_n,
    input  logic                         clear,
    input  logic                         push,
    input  fir_pkg::sample_t             push_data,
    input  logic [$clog2(NUM_TAPS)-1:0]  age,
    output fir_pkg::sample_t             sample
);
    import fir_pkg::*;

    localparam int IDX_W = $clog2(NUM_TAPS);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(NUM_TAPS - 1);

    sample_t          hist [NUM_TAPS];
    logic [IDX_W-1:0] head;       // Slot of the newest sample.
    logic [IDX_W-1:0] head_next;
    logic [IDX_W-1:0] rd_idx;

    assign head_next = (head == LAST) ? '0 : head + 1'b1;

    // Wraps modulo NUM_TAPS; the sum stays correct even if the top bit rolls over.
    assign rd_idx = (age > head) ? head + IDX_W'(NUM_TAPS) - age : head - age;
    assign sample = hist[rd_idx];

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            head <= '0;
        end else if (clear) begin
            head <= '0;
        end else if (push) begin
            head <= head_next;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (clear) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                hist[k] <= '0;
            end
        end else if (push) begin
            hist[head_next] <= push_data;
        end
    end

endmodule

// ==== logic/fir_coef_store.sv ====
`timescale 1ns/1ns
module fir_coef_store #(
    parameter int NUM_TAPS = 11
) (
    input  logic                         axis_clk,
    input  fir_pkg::cfg_wr_t             cfg_wr,
    input  logic                         tap_we,
    input  logic [$clog2(NUM_TAPS)-1:0]  mac_idx,
    output fir_pkg::sample_t             mac_coef,
    input  logic [fir_pkg::ADDR_W-3:0]   cfg_idx,
    output fir_pkg::sample_t             cfg_coef
);
    import fir_pkg::*;

    localparam int IDX_W = $clog2(NUM_TAPS);

    sample_t           coef [NUM_TAPS];
    logic [ADDR_W-3:0] wr_idx;

    assign wr_idx = cfg_wr.addr[ADDR_W-1:2] - ADDR_TAP_BASE[ADDR_W-1:2];

    always_ff @(posedge axis_clk) begin
        for (int k = 0; k < NUM_TAPS; k++) begin
            if (tap_we && wr_idx == k) begin
                coef[k] <= cfg_wr.data;
            end
        end
    end

    assign mac_coef = coef[mac_idx];

    // Taps past the end read like any unmapped register.
    assign cfg_coef = (cfg_idx < NUM_TAPS) ? coef[cfg_idx[IDX_W-1:0]] : '1;

endmodule

// ==== logic/fir_pkg.sv ====
package fir_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Register map. Tap k sits at ADDR_TAP_BASE + 4*k.
    localparam addr_t ADDR_AP_CTRL  = 12'h000;
    localparam addr_t ADDR_DATA_LEN = 12'h010;
    localparam addr_t ADDR_TAP_BASE = 12'h020;

    localparam sample_t SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam sample_t SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // One-cycle write strobe from the configuration slave.
    typedef struct packed {
        logic    valid;
        addr_t   addr;
        sample_t data;
    } cfg_wr_t;

    // Declared so that start lands in bit 0 and idle in bit 2.
    typedef struct packed {
        logic idle;
        logic done;
        logic start;
    } ap_status_t;

    typedef struct packed {
        logic    clear;
        sample_t coef;
        sample_t sample;
    } mac_op_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_IN,
        CALC,
        OUT,
        FINISH
    } fir_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

endpackage
